/* verilog/prefetch_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the instruction prefetch buffer
// The bus is 32 bits wide and word aligned, so the two low
// address bits are always zero on the bus and at the output
////////////////////////////////////////////////////////////

`default_nettype none

package prefetch_pkg;

  // Width of an instruction address and of an instruction word
  parameter int unsigned AddrW = 32;

  typedef logic [AddrW-1:0] addr_t;

  // One response beat from the instruction bus
  typedef struct packed {
    logic  rvalid;
    addr_t rdata;
    logic  err;
  } mem_rsp_t;

  // One instruction word as handed to the core
  typedef struct packed {
    addr_t rdata;
    addr_t addr;
    logic  err;
  } fetch_out_t;

  // State of one outstanding-request slot
  // Pending means granted and still waiting for data, discard means the data is stale
  typedef struct packed {
    logic pending;
    logic discard;
  } slot_state_t;

endpackage

`default_nettype wire

/* verilog/fetch_request_ctrl.sv */
////////////////////////////////////////////////////////////
// Request side of the prefetch buffer
// Fetch addresses only advance in whole words
// The next fetch address holds no valid value until the first branch
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_request_ctrl #(
  parameter int unsigned NumReqs = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    req_i,
  input  logic                                    branch_i,
  input  prefetch_pkg::addr_t                     addr_i,
  input  logic                                    space_i,
  input  prefetch_pkg::slot_state_t [NumReqs-1:0] slots_i,
  input  logic                                    instr_gnt_i,
  output logic                                    instr_req_o,
  output prefetch_pkg::addr_t                     instr_addr_o,
  output logic [NumReqs-1:0]                      alloc_o,
  output logic                                    discard_req_o
);
  import prefetch_pkg::*;

  localparam int unsigned PtrW = (NumReqs > 1) ? $clog2(NumReqs) : 1;

  logic            valid_req_q;
  logic            valid_req;
  logic            new_req;
  logic            issue;
  logic            discard_req_d;
  logic            discard_req_q;
  logic [PtrW-1:0] wr_ptr_q;
  addr_t           stored_addr_q;
  addr_t           fetch_addr_q;
  addr_t           fetch_base;
  addr_t           instr_addr;

  ////////////////////////////////////////////////////////////
  // Request issue
  ////////////////////////////////////////////////////////////

  // A branch may issue even when the FIFO looks full, since the FIFO is flushed by it
  assign new_req = req_i & (space_i | branch_i) & ~slots_i[wr_ptr_q].pending;

  // A request that was not granted stays on the bus
  assign valid_req = valid_req_q | new_req;

  // A fresh request, as opposed to one still waiting for its grant
  assign issue = new_req & ~valid_req_q;

  // A held request was issued before the branch, so its data is already stale
  assign discard_req_d = valid_req_q & (branch_i | discard_req_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_req_q   <= 1'b0;
      discard_req_q <= 1'b0;
      wr_ptr_q      <= '0;
    end else begin
      valid_req_q   <= valid_req & ~instr_gnt_i;
      discard_req_q <= discard_req_d;
      // Each grant takes the slot under the write pointer
      if (valid_req & instr_gnt_i) begin
        if (wr_ptr_q == PtrW'(NumReqs - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Fetch addresses
  ////////////////////////////////////////////////////////////

  // Keep the bus address of a request that goes ungranted
  always_ff @(posedge clk_i) begin
    if (issue & ~instr_gnt_i) begin
      stored_addr_q <= instr_addr;
    end
  end

  // Next fetch address, reloaded by a branch and stepped by a word per new request
  assign fetch_base = branch_i ? {addr_i[AddrW-1:2], 2'b00} : fetch_addr_q;

  always_ff @(posedge clk_i) begin
    if (branch_i | issue) begin
      fetch_addr_q <= fetch_base + (issue ? AddrW'(4) : AddrW'(0));
    end
  end

  // A held request wins over a branch so the bus address stays stable
  assign instr_addr = valid_req_q ? stored_addr_q :
                      branch_i    ? addr_i        :
                                    fetch_addr_q;

  assign instr_req_o   = valid_req;
  assign instr_addr_o  = {instr_addr[AddrW-1:2], 2'b00};
  assign discard_req_o = discard_req_d;

  // One-hot slot allocation in the cycle of the grant
  always_comb begin
    alloc_o = '0;
    if (valid_req & instr_gnt_i) begin
      alloc_o[wr_ptr_q] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/outstanding_slot.sv */
////////////////////////////////////////////////////////////
// One outstanding-request slot
// Allocation and retirement never hit the same slot in one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module outstanding_slot (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      alloc_i,
  input  logic                      discard_req_i,
  input  logic                      branch_i,
  input  logic                      retire_i,
  output prefetch_pkg::slot_state_t state_o
);
  import prefetch_pkg::*;

  slot_state_t state_d;
  slot_state_t state_q;

  always_comb begin
    state_d = state_q;
    if (alloc_i) begin
      // The grant may already be stale when a branch came while it was held
      state_d.pending = 1'b1;
      state_d.discard = discard_req_i;
    end else if (retire_i) begin
      // The response for this slot has arrived
      state_d = '0;
    end else if (branch_i && state_q.pending) begin
      // Data still in flight now belongs to the old instruction stream
      state_d.discard = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

/* verilog/fetch_fifo.sv */
////////////////////////////////////////////////////////////
// Fetch FIFO, NumReqs entries deep, registered output
// Responses must arrive in request order
// A branch flushes it in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module fetch_fifo #(
  parameter int unsigned NumReqs = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    branch_i,
  input  prefetch_pkg::addr_t                     addr_i,
  input  prefetch_pkg::mem_rsp_t                  rsp_i,
  input  prefetch_pkg::slot_state_t [NumReqs-1:0] slots_i,
  input  logic                                    ready_i,
  output logic                                    space_o,
  output logic [NumReqs-1:0]                      retire_o,
  output logic                                    valid_o,
  output prefetch_pkg::fetch_out_t                out_o
);
  import prefetch_pkg::*;

  localparam int unsigned PtrW = (NumReqs > 1) ? $clog2(NumReqs) : 1;
  localparam int unsigned CntW = $clog2(NumReqs + 1);

  logic [PtrW-1:0]    rd_slot_q;
  logic [PtrW-1:0]    head_q;
  logic [PtrW-1:0]    tail_q;
  logic [CntW-1:0]    cnt_q;
  logic [CntW-1:0]    pend_cnt;
  logic [CntW:0]      fill;
  logic               push;
  logic               pop;
  addr_t              head_addr_q;
  addr_t              data_q [NumReqs];
  logic [NumReqs-1:0] err_q;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(NumReqs - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Slot retirement and space
  ////////////////////////////////////////////////////////////

  // Every response retires the oldest slot, whether its data is kept or not
  always_comb begin
    retire_o = '0;
    if (rsp_i.rvalid) begin
      retire_o[rd_slot_q] = 1'b1;
    end
  end

  // Granted requests still reserve an entry until their data returns
  always_comb begin
    pend_cnt = '0;
    for (int i = 0; i < NumReqs; i++) begin
      pend_cnt = pend_cnt + CntW'(slots_i[i].pending);
    end
  end

  assign fill    = {1'b0, cnt_q} + {1'b0, pend_cnt};
  assign space_o = fill < (CntW + 1)'(NumReqs);

  // Data of a stale request, or one arriving with a branch, never enters
  assign push    = rsp_i.rvalid & ~slots_i[rd_slot_q].discard & ~branch_i;
  assign valid_o = cnt_q != '0;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_slot_q <= '0;
      head_q    <= '0;
      tail_q    <= '0;
      cnt_q     <= '0;
    end else begin
      if (rsp_i.rvalid) begin
        rd_slot_q <= next_ptr(rd_slot_q);
      end
      if (branch_i) begin
        head_q <= '0;
        tail_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (push) begin
          tail_q <= next_ptr(tail_q);
        end
        if (pop) begin
          head_q <= next_ptr(head_q);
        end
        if (push && !pop) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (pop && !push) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Storage and head address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[tail_q] <= rsp_i.rdata;
      err_q[tail_q]  <= rsp_i.err;
    end
  end

  // Address of the oldest word, stepped once per word handed out
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      head_addr_q <= {addr_i[AddrW-1:2], 2'b00};
    end else if (pop) begin
      head_addr_q <= head_addr_q + AddrW'(4);
    end
  end

  always_comb begin
    out_o.rdata = data_q[head_q];
    out_o.addr  = head_addr_q;
    out_o.err   = err_q[head_q];
  end

endmodule

`default_nettype wire

/* verilog/prefetch_buffer.sv */
////////////////////////////////////////////////////////////
// Instruction prefetch buffer, top level
// The core must branch once after reset before it fetches
// NumReqs sets both the outstanding requests and the FIFO depth
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned NumReqs = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  prefetch_pkg::addr_t      addr_i,
  input  logic                     ready_i,
  output logic                     valid_o,
  output prefetch_pkg::fetch_out_t out_o,
  output logic                     instr_req_o,
  output prefetch_pkg::addr_t      instr_addr_o,
  input  logic                     instr_gnt_i,
  input  prefetch_pkg::mem_rsp_t   rsp_i,
  output logic                     busy_o
);
  import prefetch_pkg::*;

  slot_state_t [NumReqs-1:0] slots;
  logic [NumReqs-1:0]        alloc;
  logic [NumReqs-1:0]        retire;
  logic [NumReqs-1:0]        pending;
  logic                      space;
  logic                      discard_req;

  ////////////////////////////////////////////////////////////
  // Request control
  ////////////////////////////////////////////////////////////

  fetch_request_ctrl #(
    .NumReqs (NumReqs)
  ) request_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .addr_i        (addr_i),
    .space_i       (space),
    .slots_i       (slots),
    .instr_gnt_i   (instr_gnt_i),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .alloc_o       (alloc),
    .discard_req_o (discard_req)
  );

  // Slots form a ring, filled at the write pointer and drained at the read pointer
  for (genvar i = 0; i < NumReqs; i++) begin : g_slots
    outstanding_slot slot_i (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .alloc_i       (alloc[i]),
      .discard_req_i (discard_req),
      .branch_i      (branch_i),
      .retire_i      (retire[i]),
      .state_o       (slots[i])
    );
    assign pending[i] = slots[i].pending;
  end

  ////////////////////////////////////////////////////////////
  // Fetch FIFO
  ////////////////////////////////////////////////////////////

  fetch_fifo #(
    .NumReqs (NumReqs)
  ) fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .branch_i (branch_i),
    .addr_i   (addr_i),
    .rsp_i    (rsp_i),
    .slots_i  (slots),
    .ready_i  (ready_i),
    .space_o  (space),
    .retire_o (retire),
    .valid_o  (valid_o),
    .out_o    (out_o)
  );

  // Busy while a request sits on the bus or any data is still owed
  assign busy_o = instr_req_o | (|pending);

endmodule

`default_nettype wire

/* testbench/instr_mem_model.sv */
////////////////////////////////////////////////////////////
// Instruction memory model with random grant and response delays
// Data is the inverted address, err is set inside [ErrLo, ErrHi]
// Responses come back in request order, at most one per cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module instr_mem_model #(
  parameter prefetch_pkg::addr_t ErrLo = '0,
  parameter prefetch_pkg::addr_t ErrHi = '0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [3:0]             max_delay_i,
  input  logic                   req_i,
  input  prefetch_pkg::addr_t    addr_i,
  output logic                   gnt_o,
  output prefetch_pkg::mem_rsp_t rsp_o
);
  import prefetch_pkg::*;

  logic [31:0] lcg_state;
  logic [3:0]  gnt_wait;
  logic [3:0]  rsp_wait;
  addr_t       pend_q[$];

  // Linear congruential generator, seeded with 59 at reset
  function automatic logic [3:0] next_delay(input logic [3:0] max);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return 4'((lcg_state >> 16) % (32'(max) + 32'd1));
  endfunction

  // Grant as soon as the grant delay has run out
  assign gnt_o = req_i & (gnt_wait == '0);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lcg_state = 32'd59;
      pend_q.delete();
      gnt_wait <= '0;
      rsp_wait <= '0;
      rsp_o    <= '0;
    end else begin
      rsp_o <= '0;
      // The oldest granted request answers once its latency is over
      if (pend_q.size() != 0) begin
        if (rsp_wait == '0) begin
          rsp_o.rvalid <= 1'b1;
          rsp_o.rdata  <= ~pend_q[0];
          rsp_o.err    <= (pend_q[0] >= ErrLo) && (pend_q[0] <= ErrHi);
          void'(pend_q.pop_front());
          rsp_wait <= next_delay(max_delay_i);
        end else begin
          rsp_wait <= rsp_wait - 1'b1;
        end
      end
      // A granted address joins the queue of owed responses
      if (req_i) begin
        if (gnt_wait == '0) begin
          pend_q.push_back(addr_i);
          gnt_wait <= next_delay(max_delay_i);
        end else begin
          gnt_wait <= gnt_wait - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_prefetch_buffer.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the instruction prefetch buffer
// Inputs change on the falling edge, outputs are read there too
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_prefetch_buffer;
  import prefetch_pkg::*;

  localparam int unsigned NumReqs = 2;
  localparam int          Timeout = 200;
  localparam addr_t       ErrLo   = 32'h0000_2010;
  localparam addr_t       ErrHi   = 32'h0000_201c;

  logic       clk;
  logic       rst_n;
  logic       req;
  logic       branch;
  addr_t      addr;
  logic       ready;
  logic       valid;
  fetch_out_t out;
  logic       instr_req;
  addr_t      instr_addr;
  logic       instr_gnt;
  mem_rsp_t   rsp;
  logic       busy;
  logic [3:0] max_delay;
  int         errors;
  int         tests;
  int         start_errors;
  int         err_seen;
  addr_t      expect_addr;

  prefetch_buffer #(
    .NumReqs (NumReqs)
  ) dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .branch_i     (branch),
    .addr_i       (addr),
    .ready_i      (ready),
    .valid_o      (valid),
    .out_o        (out),
    .instr_req_o  (instr_req),
    .instr_addr_o (instr_addr),
    .instr_gnt_i  (instr_gnt),
    .rsp_i        (rsp),
    .busy_o       (busy)
  );

  instr_mem_model #(
    .ErrLo (ErrLo),
    .ErrHi (ErrHi)
  ) mem_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .max_delay_i (max_delay),
    .req_i       (instr_req),
    .addr_i      (instr_addr),
    .gnt_o       (instr_gnt),
    .rsp_o       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic in_err_window(input addr_t a);
    return (a >= ErrLo) && (a <= ErrHi);
  endfunction

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, Timeout);
    $display("sim failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  // Restart the stream at target, FIFO must be empty one cycle later
  task automatic branch_to(input addr_t target);
    @(negedge clk);
    req    = 1'b1;
    branch = 1'b1;
    addr   = target;
    ready  = 1'b0;
    @(negedge clk);
    branch      = 1'b0;
    expect_addr = {target[31:2], 2'b00};
    if (valid !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: valid_o high in the cycle after a branch", $time);
    end
  endtask

  // Stall for some cycles, then take n words that must follow the word sequence
  task automatic receive_items(input int n, input int stall);
    int got;
    int waited;
    got    = 0;
    waited = 0;
    ready  = 1'b0;
    repeat (stall) @(negedge clk);
    if (stall > 0 && (instr_req !== 1'b0 || valid !== 1'b1)) begin
      errors++;
      $display("mismatch at %0t: after stall instr_req_o=%b valid_o=%b, expected 0 and 1",
               $time, instr_req, valid);
    end
    while (got < n) begin
      ready = 1'b1;
      if (valid === 1'b1) begin
        if (out.addr !== expect_addr || out.rdata !== ~expect_addr ||
            out.err !== in_err_window(expect_addr)) begin
          errors++;
          $display("mismatch at %0t: got addr %h data %h err %b, expected %h %h %b", $time,
                   out.addr, out.rdata, out.err, expect_addr, ~expect_addr,
                   in_err_window(expect_addr));
        end
        err_seen    += int'(out.err === 1'b1);
        expect_addr += 32'd4;
        got++;
        waited = 0;
      end else if (waited > Timeout) begin
        report_timeout("delivery of the next instruction");
      end else begin
        waited++;
      end
      @(negedge clk);
    end
    ready = 1'b0;
  endtask

  // Wait until busy_o reaches the given level
  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    while (busy !== level) begin
      if (waited > Timeout) begin
        report_timeout("the expected busy level");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    start_errors = errors;
    @(negedge clk);
    if (valid !== 1'b0 || instr_req !== 1'b0 || busy !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: after reset valid_o=%b instr_req_o=%b busy_o=%b",
               $time, valid, instr_req, busy);
    end
    finish_test("reset state");
  endtask

  task automatic test_sequential_fetch();
    start_errors = errors;
    branch_to(32'h0000_1000);
    receive_items(10, 0);
    finish_test("sequential fetch");
  endtask

  // Continues the stream of the previous test after a long stall
  task automatic test_backpressure();
    start_errors = errors;
    receive_items(8, 40);
    finish_test("back-pressure");
  endtask

  task automatic test_branch_pending();
    start_errors = errors;
    max_delay = 4'd12;
    branch_to(32'h0000_3000);
    receive_items(2, 0);
    wait_busy(1'b1);
    branch_to(32'h0000_4000);
    receive_items(6, 0);
    finish_test("branch while pending");
  endtask

  task automatic test_error_window();
    start_errors = errors;
    max_delay = 4'd4;
    err_seen  = 0;
    branch_to(32'h0000_2000);
    receive_items(12, 0);
    // Four words fall inside the window
    if (err_seen != 4) begin
      errors++;
      $display("mismatch at %0t: %0d words with err, expected 4", $time, err_seen);
    end
    finish_test("error window");
  endtask

  task automatic test_idle();
    start_errors = errors;
    @(negedge clk);
    req = 1'b0;
    wait_busy(1'b0);
    repeat (20) begin
      @(negedge clk);
      if (instr_req !== 1'b0 || busy !== 1'b0) begin
        errors++;
        $display("mismatch at %0t: request or busy while idle", $time);
      end
    end
    finish_test("idle");
  endtask

  initial begin
    req       = 1'b0;
    branch    = 1'b0;
    addr      = '0;
    ready     = 1'b0;
    max_delay = 4'd4;
    rst_n     = 1'b0;
    errors    = 0;
    tests     = 0;
    err_seen  = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_sequential_fetch();
    test_backpressure();
    test_branch_pending();
    test_error_window();
    test_idle();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/prefetch_pkg.sv
verilog/fetch_request_ctrl.sv
verilog/outstanding_slot.sv
verilog/fetch_fifo.sv
verilog/prefetch_buffer.sv
testbench/instr_mem_model.sv
testbench/tb_prefetch_buffer.sv

/* Bender.yml */
package:
  name: prefetch_buffer

sources:
  - verilog/prefetch_pkg.sv
  - verilog/fetch_request_ctrl.sv
  - verilog/outstanding_slot.sv
  - verilog/fetch_fifo.sv
  - verilog/prefetch_buffer.sv
  - target: test
    files:
      - testbench/instr_mem_model.sv
      - testbench/tb_prefetch_buffer.sv
